// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_adc_rx -f src.f -o sim_adc_rx
	@out="$$(./obj_dir/sim_adc_rx)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// ==== rtl/adc_lane_deser.sv ====
`timescale 1ns/100ps

module adc_lane_deser (
	input  logic                                  CMS_CLK_P,
	input  logic                                  rst_n,
	input  logic [adc_rx_pkg::LANES-1:0]          adc_lanes,
	input  logic                                  adc_frame,
	output logic                                  set_valid,
	output logic [adc_rx_pkg::SET_BITS-1:0]       set_samples,
	output logic [adc_rx_pkg::SET_NUM_BITS-1:0]   set_num
);

	logic                                 active;   // Inside a frame
	logic [adc_rx_pkg::CNT_BITS-1:0]      bit_cnt;  // Next bit position
	logic [adc_rx_pkg::CNT_BITS-1:0]      bit_pos;
	logic                                 capture;

	// Frame strobe comes with bit 0 and always restarts the count
	assign bit_pos = adc_frame ? '0 : bit_cnt;
	assign capture = adc_frame | active;

	//////////////////////////////////////////////////
	// Frame alignment and set numbering
	//////////////////////////////////////////////////
	always_ff @(posedge CMS_CLK_P or negedge rst_n) begin
		if (!rst_n) begin
			active    <= 1'b0;
			bit_cnt   <= '0;
			set_valid <= 1'b0;
			set_num   <= '0;
		end else begin
			set_valid <= 1'b0;
			if (set_valid)
				set_num <= set_num + 1'b1;  // Number held through the pulse
			if (adc_frame) begin
				active  <= 1'b1;  // Partial set, if any, is abandoned
				bit_cnt <= adc_rx_pkg::CNT_BITS'(1);
			end else if (active) begin
				if (bit_cnt == adc_rx_pkg::SAMPLE_BITS - 1) begin
					active    <= 1'b0;
					set_valid <= 1'b1;  // Bit 11 taken this edge
				end
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	// Lane bits land LSB first at the counter position
	always_ff @(posedge CMS_CLK_P) begin
		if (capture) begin
			for (int l = 0; l < adc_rx_pkg::LANES; l++) begin
				set_samples[l*adc_rx_pkg::SAMPLE_BITS + bit_pos] <= adc_lanes[l];
			end
		end
	end

endmodule

// ==== rtl/adc_rx_pkg.sv ====
package adc_rx_pkg;

	//////////////////////////////////////////////////
	// ADC group geometry
	//////////////////////////////////////////////////
	localparam int LANES        = 16;  // One channel per serial lane
	localparam int SAMPLE_BITS  = 12;  // LSB first on the wire
	localparam int CHAN_BITS    = 4;
	localparam int SET_NUM_BITS = 8;

	//////////////////////////////////////////////////
	// Buffering and flow control
	//////////////////////////////////////////////////
	localparam int SET_DEPTH = 2;
	localparam int CREDITS   = 4;   // Also the credit ceiling
	localparam int DROP_BITS = 8;

	// Derived counter widths
	localparam int CNT_BITS    = $clog2(SAMPLE_BITS);
	localparam int PTR_BITS    = $clog2(SET_DEPTH);
	localparam int FILL_BITS   = $clog2(SET_DEPTH + 1);
	localparam int CREDIT_BITS = $clog2(CREDITS + 1);

	localparam int SET_BITS = LANES * SAMPLE_BITS;  // One full sample set

endpackage

// ==== rtl/adc_rx_top.sv ====
`timescale 1ns/100ps

module adc_rx_top (
	input  logic                                  CMS_CLK_P,
	input  logic                                  rst_n,
	input  logic [adc_rx_pkg::LANES-1:0]          adc_lanes,
	input  logic                                  adc_frame,
	input  logic                                  credit_return,
	output logic                                  sample_valid,
	output logic [adc_rx_pkg::CHAN_BITS-1:0]      sample_chan,
	output logic [adc_rx_pkg::SAMPLE_BITS-1:0]    sample_data,
	output logic [adc_rx_pkg::SET_NUM_BITS-1:0]   sample_set,
	output logic                                  sample_last,
	output logic [adc_rx_pkg::DROP_BITS-1:0]      dropped_sets
);

	// Deserializer to buffer
	logic                                 set_valid;
	logic [adc_rx_pkg::SET_BITS-1:0]      set_samples;
	logic [adc_rx_pkg::SET_NUM_BITS-1:0]  set_num;

	sample_set_if set_bus ();  // Buffer head to sequencer

	//////////////////////////////////////////////////
	// Receive path
	//////////////////////////////////////////////////
	adc_lane_deser u_deser (
		.CMS_CLK_P   (CMS_CLK_P),
		.rst_n       (rst_n),
		.adc_lanes   (adc_lanes),
		.adc_frame   (adc_frame),
		.set_valid   (set_valid),
		.set_samples (set_samples),
		.set_num     (set_num)
	);

	sample_set_fifo u_fifo (
		.CMS_CLK_P    (CMS_CLK_P),
		.rst_n        (rst_n),
		.set_valid    (set_valid),
		.set_samples  (set_samples),
		.set_num      (set_num),
		.out_set      (set_bus.producer),
		.dropped_sets (dropped_sets)
	);

	channel_sequencer u_seq (
		.CMS_CLK_P     (CMS_CLK_P),
		.rst_n         (rst_n),
		.credit_return (credit_return),
		.in_set        (set_bus.consumer),
		.sample_valid  (sample_valid),
		.sample_chan   (sample_chan),
		.sample_data   (sample_data),
		.sample_set    (sample_set),
		.sample_last   (sample_last)
	);

endmodule

// ==== rtl/channel_sequencer.sv ====
`timescale 1ns/100ps

module channel_sequencer (
	input  logic                                  CMS_CLK_P,
	input  logic                                  rst_n,
	input  logic                                  credit_return,
	sample_set_if.consumer                        in_set,
	output logic                                  sample_valid,
	output logic [adc_rx_pkg::CHAN_BITS-1:0]      sample_chan,
	output logic [adc_rx_pkg::SAMPLE_BITS-1:0]    sample_data,
	output logic [adc_rx_pkg::SET_NUM_BITS-1:0]   sample_set,
	output logic                                  sample_last
);

	logic [adc_rx_pkg::SET_BITS-1:0]      cur_samples;
	logic [adc_rx_pkg::SET_NUM_BITS-1:0]  cur_num;
	logic [adc_rx_pkg::CHAN_BITS-1:0]     chan;
	logic                                 busy;      // Holding a set
	logic [adc_rx_pkg::CREDIT_BITS-1:0]   credits;
	logic                                 emit;
	logic                                 finishing;

	assign emit      = busy & (credits != '0);
	assign finishing = emit & (chan == adc_rx_pkg::LANES - 1);

	// Next set may be taken on the last word of the current one
	assign in_set.take = in_set.avail & (~busy | finishing);

	//////////////////////////////////////////////////
	// Set tracking and credit count
	//////////////////////////////////////////////////
	always_ff @(posedge CMS_CLK_P or negedge rst_n) begin
		if (!rst_n) begin
			busy         <= 1'b0;
			chan         <= '0;
			credits      <= adc_rx_pkg::CREDIT_BITS'(adc_rx_pkg::CREDITS);
			sample_valid <= 1'b0;
			sample_last  <= 1'b0;
		end else begin
			sample_valid <= emit;
			sample_last  <= finishing;
			if (in_set.take) begin
				busy <= 1'b1;
				chan <= '0;
			end else if (finishing) begin
				busy <= 1'b0;
			end else if (emit) begin
				chan <= chan + 1'b1;
			end

			case ({emit, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: begin
					if (credits < adc_rx_pkg::CREDITS)
						credits <= credits + 1'b1;  // Clamp at ceiling
				end
				default: credits <= credits;  // Spend and return cancel
			endcase
		end
	end

	// Current set and output word payload
	always_ff @(posedge CMS_CLK_P) begin
		if (in_set.take) begin
			cur_samples <= in_set.samples;
			cur_num     <= in_set.set_num;
		end
		if (emit) begin
			sample_chan <= chan;
			sample_data <= cur_samples[chan*adc_rx_pkg::SAMPLE_BITS +: adc_rx_pkg::SAMPLE_BITS];
			sample_set  <= cur_num;
		end
	end

endmodule

// ==== rtl/sample_set_fifo.sv ====
`timescale 1ns/100ps

module sample_set_fifo (
	input  logic                                  CMS_CLK_P,
	input  logic                                  rst_n,
	input  logic                                  set_valid,
	input  logic [adc_rx_pkg::SET_BITS-1:0]       set_samples,
	input  logic [adc_rx_pkg::SET_NUM_BITS-1:0]   set_num,
	sample_set_if.producer                        out_set,
	output logic [adc_rx_pkg::DROP_BITS-1:0]      dropped_sets
);

	logic [adc_rx_pkg::SET_BITS-1:0]      mem_samples [adc_rx_pkg::SET_DEPTH];
	logic [adc_rx_pkg::SET_NUM_BITS-1:0]  mem_num     [adc_rx_pkg::SET_DEPTH];

	logic [adc_rx_pkg::PTR_BITS-1:0]      wr_ptr;
	logic [adc_rx_pkg::PTR_BITS-1:0]      rd_ptr;
	logic [adc_rx_pkg::FILL_BITS-1:0]     fill;
	logic                                 full;
	logic                                 wr_en;
	logic                                 rd_en;

	assign full  = (fill == adc_rx_pkg::SET_DEPTH);
	assign wr_en = set_valid & ~full;  // Full drops the set even with a take pending
	assign rd_en = out_set.take & out_set.avail;

	// Head entry
	assign out_set.avail   = (fill != '0);
	assign out_set.samples = mem_samples[rd_ptr];
	assign out_set.set_num = mem_num[rd_ptr];

	//////////////////////////////////////////////////
	// Pointers, fill level, drop counter
	//////////////////////////////////////////////////
	always_ff @(posedge CMS_CLK_P or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			fill         <= '0;
			dropped_sets <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;  // Both or neither
			endcase
			if (set_valid && full && dropped_sets != '1)
				dropped_sets <= dropped_sets + 1'b1;  // Saturates
		end
	end

	// Storage
	always_ff @(posedge CMS_CLK_P) begin
		if (wr_en) begin
			mem_samples[wr_ptr] <= set_samples;
			mem_num[wr_ptr]     <= set_num;
		end
	end

endmodule

// ==== rtl/sample_set_if.sv ====
`timescale 1ns/100ps

// Head of the set buffer as seen by the sequencer
interface sample_set_if;

	logic                                  avail;   // Head entry valid
	logic [adc_rx_pkg::SET_BITS-1:0]       samples; // Channel n at bits n*SAMPLE_BITS
	logic [adc_rx_pkg::SET_NUM_BITS-1:0]   set_num;
	logic                                  take;    // Pops the head at the edge

	modport producer (
		output avail,
		output samples,
		output set_num,
		input  take
	);

	modport consumer (
		input  avail,
		input  samples,
		input  set_num,
		output take
	);

endinterface

// ==== src.f ====
rtl/adc_rx_pkg.sv
rtl/sample_set_if.sv
rtl/adc_lane_deser.sv
rtl/sample_set_fifo.sv
rtl/channel_sequencer.sv
rtl/adc_rx_top.sv
testbench/tb_adc_rx.sv

// ==== testbench/tb_adc_rx.sv ====
`timescale 1ns/100ps

module tb_adc_rx;

	localparam int PERIOD_NS       = 40;
	localparam int FRAME_TOTAL     = 20 + 4 + 3 + 6;  // Frames over all tests
	localparam int WATCHDOG_CYCLES = FRAME_TOTAL * 40 + 600;

	logic                                 CMS_CLK_P;
	logic                                 rst_n;
	logic [adc_rx_pkg::LANES-1:0]         adc_lanes;
	logic                                 adc_frame;
	logic                                 credit_return;
	logic                                 sample_valid;
	logic [adc_rx_pkg::CHAN_BITS-1:0]     sample_chan;
	logic [adc_rx_pkg::SAMPLE_BITS-1:0]   sample_data;
	logic [adc_rx_pkg::SET_NUM_BITS-1:0]  sample_set;
	logic                                 sample_last;
	logic [adc_rx_pkg::DROP_BITS-1:0]     dropped_sets;

	// Reference model state
	logic [adc_rx_pkg::SAMPLE_BITS-1:0]   exp_data [$];
	logic [adc_rx_pkg::CHAN_BITS-1:0]     exp_chan [$];
	logic [adc_rx_pkg::SET_NUM_BITS-1:0]  exp_set  [$];
	logic [adc_rx_pkg::SET_NUM_BITS-1:0]  next_num;    // Every complete frame takes one
	logic [adc_rx_pkg::DROP_BITS-1:0]     exp_drops;
	int                                   resident;    // Sets accepted, last word not yet seen
	int                                   credit_owed;
	logic                                 credit_hold;
	int                                   words_seen;
	int                                   pause_base;

	int    seed = 28879;
	int    errors;
	int    checks;
	int    tests_run;
	int    test_err_base;
	string cur_test;

	// Monitor scratch
	logic [adc_rx_pkg::SAMPLE_BITS-1:0]   e_data;
	logic [adc_rx_pkg::CHAN_BITS-1:0]     e_chan;
	logic [adc_rx_pkg::SET_NUM_BITS-1:0]  e_set;
	logic                                 e_last;

	adc_rx_top DUT (
		.CMS_CLK_P     (CMS_CLK_P),
		.rst_n         (rst_n),
		.adc_lanes     (adc_lanes),
		.adc_frame     (adc_frame),
		.credit_return (credit_return),
		.sample_valid  (sample_valid),
		.sample_chan   (sample_chan),
		.sample_data   (sample_data),
		.sample_set    (sample_set),
		.sample_last   (sample_last),
		.dropped_sets  (dropped_sets)
	);

	initial begin
		CMS_CLK_P = 1'b0;
		forever #(PERIOD_NS / 2) CMS_CLK_P = ~CMS_CLK_P;
	end

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////
	task automatic check_sample(input logic [adc_rx_pkg::SAMPLE_BITS-1:0] expected,
		input logic [adc_rx_pkg::SAMPLE_BITS-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL %s sample: expected %h, actual %h", cur_test, expected, actual);
		end
	endtask

	task automatic check_set(input logic [adc_rx_pkg::SET_NUM_BITS-1:0] expected,
		input logic [adc_rx_pkg::SET_NUM_BITS-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL %s set number: expected %0d, actual %0d", cur_test, expected, actual);
		end
	endtask

	task automatic check_chan(input logic [adc_rx_pkg::CHAN_BITS-1:0] expected,
		input logic [adc_rx_pkg::CHAN_BITS-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL %s channel: expected %0d, actual %0d", cur_test, expected, actual);
		end
	endtask

	task automatic check_drops(input logic [adc_rx_pkg::DROP_BITS-1:0] expected,
		input logic [adc_rx_pkg::DROP_BITS-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL %s dropped sets: expected %0d, actual %0d",
				cur_test, expected, actual);
		end
	endtask

	task automatic check_flag(input string what, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL %s %s: expected %b, actual %b", cur_test, what, expected, actual);
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus and model
	//////////////////////////////////////////////////
	// Strobe with bit 0 and nbits-1 more bits then idle up to period
	task automatic drive_frame(input int nbits, input int period);
		logic [adc_rx_pkg::SAMPLE_BITS-1:0] smp [adc_rx_pkg::LANES];
		logic [31:0]                        rnd;
		logic [adc_rx_pkg::CHAN_BITS-1:0]   ch;
		for (int l = 0; l < adc_rx_pkg::LANES; l++) begin
			rnd    = $random(seed);
			smp[l] = rnd[adc_rx_pkg::SAMPLE_BITS-1:0];
		end
		for (int c = 0; c < period; c++) begin
			@(posedge CMS_CLK_P);
			#2;
			rnd       = $random(seed);
			adc_frame = (c == 0);
			if (c < nbits) begin
				for (int l = 0; l < adc_rx_pkg::LANES; l++)
					adc_lanes[l] = smp[l][c];  // LSB first
			end else begin
				adc_lanes = rnd[adc_rx_pkg::LANES-1:0];  // Junk between frames
			end
			if (c == adc_rx_pkg::SAMPLE_BITS - 1 && nbits >= adc_rx_pkg::SAMPLE_BITS) begin
				// Room for one set in the sequencer plus a full buffer
				if (resident < adc_rx_pkg::SET_DEPTH + 1) begin
					resident++;
					ch = '0;
					for (int l = 0; l < adc_rx_pkg::LANES; l++) begin
						exp_chan.push_back(ch);
						exp_data.push_back(smp[l]);
						exp_set.push_back(next_num);
						ch = ch + 1'b1;
					end
				end else if (exp_drops != '1) begin
					exp_drops = exp_drops + 1'b1;
				end
				next_num = next_num + 1'b1;
			end
		end
	endtask

	task automatic wait_drain();
		while (exp_data.size() != 0 || credit_owed != 0)
			@(posedge CMS_CLK_P);
		repeat (4) @(posedge CMS_CLK_P);
		@(negedge CMS_CLK_P);
	endtask

	task automatic begin_test(input string name);
		cur_test      = name;
		test_err_base = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == test_err_base)
			$display("Test %s finished, no errors", cur_test);
		else
			$display("Test %s finished, %0d errors", cur_test, errors - test_err_base);
	endtask

	// Output word monitor against the model queues
	always @(negedge CMS_CLK_P) begin
		if (rst_n && sample_valid) begin
			words_seen++;
			credit_owed++;
			if (exp_data.size() == 0) begin
				errors++;
				$display("Test %s: the DUT sent a word that no frame accounts for", cur_test);
			end else begin
				e_data = exp_data.pop_front();
				e_chan = exp_chan.pop_front();
				e_set  = exp_set.pop_front();
				e_last = (int'(e_chan) == adc_rx_pkg::LANES - 1);
				check_chan(e_chan, sample_chan);
				check_sample(e_data, sample_data);
				check_set(e_set, sample_set);
				check_flag("last", e_last, sample_last);
				if (e_last)
					resident--;
			end
		end else if (rst_n && sample_last) begin
			errors++;
			$display("Test %s: sample_last was high without sample_valid", cur_test);
		end
	end

	// One credit back per word received unless held
	initial begin
		forever begin
			@(posedge CMS_CLK_P);
			#2;
			if (!credit_hold && credit_owed > 0) begin
				credit_return = 1'b1;
				credit_owed--;
			end else begin
				credit_return = 1'b0;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CMS_CLK_P);
		$display("Watchdog expired after %0d cycles with words still missing",
			WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////
	initial begin
		rst_n         = 1'b0;
		adc_lanes     = '0;
		adc_frame     = 1'b0;
		credit_return = 1'b0;
		credit_hold   = 1'b0;
		credit_owed   = 0;
		resident      = 0;
		next_num      = '0;
		exp_drops     = '0;
		words_seen    = 0;
		errors        = 0;
		checks        = 0;
		tests_run     = 0;
		cur_test      = "reset";
		repeat (16) @(posedge CMS_CLK_P);
		#2;
		rst_n = 1'b1;

		begin_test("reset_idle");
		repeat (20) begin
			@(negedge CMS_CLK_P);
			check_flag("valid", 1'b0, sample_valid);
			check_drops('0, dropped_sets);
		end
		end_test();

		begin_test("random_frames");
		repeat (20) drive_frame(adc_rx_pkg::SAMPLE_BITS, 40);
		wait_drain();
		check_drops(exp_drops, dropped_sets);
		end_test();

		begin_test("frame_restart");
		drive_frame(6, 6);  // Cut short by the next strobe
		repeat (3) drive_frame(adc_rx_pkg::SAMPLE_BITS, 40);
		wait_drain();
		end_test();

		begin_test("credit_pause");
		credit_hold = 1'b1;
		pause_base  = words_seen;
		repeat (3) drive_frame(adc_rx_pkg::SAMPLE_BITS, 40);
		repeat (20) @(posedge CMS_CLK_P);
		@(negedge CMS_CLK_P);
		checks++;
		if (words_seen - pause_base > adc_rx_pkg::CREDITS) begin
			errors++;
			$display("FAIL %s words while paused: expected at most %0d, actual %0d",
				cur_test, adc_rx_pkg::CREDITS, words_seen - pause_base);
		end
		credit_hold = 1'b0;
		wait_drain();
		end_test();

		begin_test("overflow");
		credit_hold = 1'b1;
		repeat (5) drive_frame(adc_rx_pkg::SAMPLE_BITS, 14);
		repeat (6) @(posedge CMS_CLK_P);
		@(negedge CMS_CLK_P);
		check_drops(exp_drops, dropped_sets);
		credit_hold = 1'b0;
		wait_drain();
		drive_frame(adc_rx_pkg::SAMPLE_BITS, 40);  // Number lands after the gap
		wait_drain();
		check_drops(exp_drops, dropped_sets);
		end_test();

		repeat (20) @(posedge CMS_CLK_P);  // Stray words still count
		@(negedge CMS_CLK_P);
		$display("Tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
